//--- verilog/sys_cfg.svh
`ifndef SYS_CFG_SVH
`define SYS_CFG_SVH

////////////////////////////////////////
// Queue depths
////////////////////////////////////////
`define TX_FIFO_DEPTH       4   // Also the number of transmit credits
`define RX_FIFO_DEPTH       8

////////////////////////////////////////
// Serial link timing
////////////////////////////////////////
`define UART_CLKS_PER_BIT   8

////////////////////////////////////////
// Bank registers after reset
////////////////////////////////////////
`define BANK0_RESET         8'hC0   // Read only, overlay on, page 0
`define BANK1_RESET         8'd33
`define BANK2_RESET         8'd34
`define BANK3_RESET         8'd19

`endif

//--- verilog/zbus_pkg.sv
`default_nettype none

package zbus_pkg;

    ////////////////////////////////////////
    // Memory banking
    ////////////////////////////////////////

    // One bank register, selected by ebus_a[15:14]
    typedef struct packed {
        logic       ro;         // Block writes to this window
        logic       overlay;    // System RAM at $3800-$3FFF
        logic [5:0] page;       // 16 KB physical page
    } bank_reg_t;

    ////////////////////////////////////////
    // I/O port map
    ////////////////////////////////////////
    typedef enum logic [7:0] {
        BANK0   = 8'hF0,
        BANK1   = 8'hF1,
        BANK2   = 8'hF2,
        BANK3   = 8'hF3,
        ESPCTRL = 8'hF4,    // Serial link status and control
        ESPDATA = 8'hF5,    // Serial link data
        KEYB    = 8'hFF     // Keyboard matrix, row select on ebus_a[15:8]
    } io_port_e;

endpackage

`default_nettype wire

//--- verilog/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // Transmit queue entry
    typedef struct packed {
        logic       brk;    // Send a break instead of data
        logic [7:0] data;
    } tx_entry_t;

    // Receive queue entry
    typedef logic [7:0] rx_entry_t;

    ////////////////////////////////////////
    // Status byte at $F4
    ////////////////////////////////////////

    // Read side
    localparam int ST_RX_NOT_EMPTY = 0;
    localparam int ST_TX_BUSY      = 1;
    localparam int ST_BREAK        = 2;     // Sticky, write 1 to clear
    localparam int ST_FRAMING      = 3;     // Sticky, write 1 to clear
    localparam int ST_OVERFLOW     = 4;     // Sticky, write 1 to clear

    // Write side, bits 2 to 4 share the read positions
    localparam int ST_TX_BREAK_REQ = 7;

endpackage

`default_nettype wire

//--- verilog/uart_if.sv
`timescale 1ns/10ps
`default_nettype none

interface uart_if import uart_pkg::*; ();

    // Transmit path, host side holds the credits
    tx_entry_t tx_entry;
    logic      tx_push;
    logic      tx_credit;      // One pulse per entry leaving the queue

    // Receive path
    rx_entry_t rx_data;        // Head of the receive queue
    logic      rx_not_empty;
    logic      rx_pop;

    // Single cycle receive events
    logic      rx_overflow;
    logic      rx_framing;
    logic      rx_break;

    modport host (
        output tx_entry, tx_push, rx_pop,
        input  tx_credit, rx_data, rx_not_empty,
        input  rx_overflow, rx_framing, rx_break
    );

    modport dev (
        input  tx_entry, tx_push, rx_pop,
        output tx_credit, rx_data, rx_not_empty,
        output rx_overflow, rx_framing, rx_break
    );

endinterface

`default_nettype wire

//--- verilog/sync_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4             // Power of two
) (
    input  wire                     sysclk,
    input  wire                     reset,
    input  wire                     wr_en,
    input  wire payload_t           wr_data,
    input  wire                     rd_en,
    output payload_t                rd_data,
    output logic                    empty,
    output logic                    full,
    output logic [$clog2(DEPTH):0]  free_count
);

    localparam int            AW         = $clog2(DEPTH);
    localparam logic [AW:0]   FULL_COUNT = (AW + 1)'(DEPTH);

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_wr;
    logic          do_rd;

    assign do_wr      = wr_en && !full;     // Writes into a full queue are ignored
    assign do_rd      = rd_en && !empty;
    assign empty      = count == '0;
    assign full       = count == FULL_COUNT;
    assign free_count = FULL_COUNT - count;
    assign rd_data    = mem[rd_ptr];        // Show-ahead head entry

    always_ff @(posedge sysclk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

    // Pointers wrap naturally at a power of two depth
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/esp_uart.sv
`timescale 1ns/10ps
`include "sys_cfg.svh"
`default_nettype none

module esp_uart import uart_pkg::*; (
    input  wire  sysclk,
    input  wire  reset,
    input  wire  esp_rx,
    input  wire  esp_cts,
    output logic esp_tx,
    output logic esp_rts,
    uart_if.dev  uart
);

    localparam int            BW        = $clog2(`UART_CLKS_PER_BIT);
    localparam logic [BW-1:0] BAUD_MAX  = BW'(`UART_CLKS_PER_BIT - 1);
    localparam logic [BW-1:0] BAUD_HALF = BW'(`UART_CLKS_PER_BIT / 2 - 1);

    // Transmit side
    tx_entry_t     tx_head;
    logic          tx_empty;
    logic          tx_start;
    logic [1:0]    cts_sync;
    logic [10:0]   tx_shift;
    logic [3:0]    tx_bits;
    logic [BW-1:0] tx_baud;

    // Receive side
    logic [2:0]    rx_sync;
    logic          rx_active;
    logic          rx_done;
    logic [3:0]    rx_cnt;
    logic [BW-1:0] rx_baud;
    logic [9:0]    rx_shift;
    logic          frame_good;
    logic          rx_push;
    logic          rx_full;
    logic          rx_empty;
    logic [$clog2(`RX_FIFO_DEPTH):0] rx_free;

    ////////////////////////////////////////
    // Transmitter
    ////////////////////////////////////////
    sync_fifo #(
        .payload_t (tx_entry_t),
        .DEPTH     (`TX_FIFO_DEPTH)
    ) tx_fifo_i (
        .sysclk     (sysclk),
        .reset      (reset),
        .wr_en      (uart.tx_push),
        .wr_data    (uart.tx_entry),
        .rd_en      (tx_start),
        .rd_data    (tx_head),
        .empty      (tx_empty),
        .full       (),
        .free_count ()
    );

    // CTS only gates the start of a new frame
    assign tx_start       = tx_bits == 4'd0 && !tx_empty && !cts_sync[1];
    assign uart.tx_credit = tx_start;
    assign esp_tx         = tx_shift[0];

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            cts_sync <= 2'b11;
            tx_shift <= '1;
            tx_bits  <= '0;
            tx_baud  <= '0;
        end else begin
            cts_sync <= {cts_sync[0], esp_cts};
            if (tx_bits == 4'd0) begin
                if (tx_start) begin
                    // Break is ten low bits plus one idle bit
                    tx_shift <= tx_head.brk ? 11'b100_0000_0000 : {2'b11, tx_head.data, 1'b0};
                    tx_bits  <= tx_head.brk ? 4'd11 : 4'd10;
                    tx_baud  <= BAUD_MAX;
                end
            end else if (tx_baud == '0) begin
                tx_shift <= {1'b1, tx_shift[10:1]};     // LSB first
                tx_bits  <= tx_bits - 1'b1;
                tx_baud  <= BAUD_MAX;
            end else begin
                tx_baud <= tx_baud - 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Receiver
    ////////////////////////////////////////
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            rx_sync   <= '1;
            rx_active <= 1'b0;
            rx_done   <= 1'b0;
            rx_cnt    <= '0;
            rx_baud   <= '0;
        end else begin
            rx_sync <= {rx_sync[1:0], esp_rx};
            rx_done <= 1'b0;
            if (!rx_active) begin
                // Falling edge only, a held low line does not retrigger
                if (rx_sync[2] && !rx_sync[1]) begin
                    rx_active <= 1'b1;
                    rx_cnt    <= '0;
                    rx_baud   <= BAUD_HALF;
                end
            end else if (rx_baud != '0) begin
                rx_baud <= rx_baud - 1'b1;
            end else begin
                rx_baud <= BAUD_MAX;
                rx_cnt  <= rx_cnt + 1'b1;
                if (rx_cnt == 4'd0 && rx_sync[1])
                    rx_active <= 1'b0;          // Glitch, not a start bit
                if (rx_cnt == 4'd9) begin
                    rx_active <= 1'b0;
                    rx_done   <= 1'b1;          // Stop bit sampled
                end
            end
        end
    end

    // Mid-bit samples, start bit ends up in bit 0 and stop bit in bit 9
    always_ff @(posedge sysclk) begin
        if (rx_active && rx_baud == '0)
            rx_shift <= {rx_sync[1], rx_shift[9:1]};
    end

    assign frame_good       = rx_done && rx_shift[9];
    assign rx_push          = frame_good && !rx_full;
    assign uart.rx_overflow = frame_good && rx_full;
    assign uart.rx_break    = rx_done && !rx_shift[9] && rx_shift[8:1] == 8'h00;
    assign uart.rx_framing  = rx_done && !rx_shift[9] && rx_shift[8:1] != 8'h00;

    sync_fifo #(
        .payload_t (rx_entry_t),
        .DEPTH     (`RX_FIFO_DEPTH)
    ) rx_fifo_i (
        .sysclk     (sysclk),
        .reset      (reset),
        .wr_en      (rx_push),
        .wr_data    (rx_shift[8:1]),
        .rd_en      (uart.rx_pop),
        .rd_data    (uart.rx_data),
        .empty      (rx_empty),
        .full       (rx_full),
        .free_count (rx_free)
    );

    assign uart.rx_not_empty = !rx_empty;

    // Ask the ESP32 to pause when nearly full
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset)
            esp_rts <= 1'b0;
        else
            esp_rts <= rx_free < 2;
    end

endmodule

`default_nettype wire

//--- verilog/bus_ctrl.sv
`timescale 1ns/10ps
`include "sys_cfg.svh"
`default_nettype none

module bus_ctrl import zbus_pkg::*, uart_pkg::*; (
    input  wire         sysclk,
    input  wire         reset,
    input  wire  [15:0] ebus_a,
    input  wire   [7:0] ebus_d_in,
    input  wire         ebus_rd_n,
    input  wire         ebus_wr_n,
    input  wire         ebus_mreq_n,
    input  wire         ebus_iorq_n,
    input  wire  [63:0] keys,
    output logic  [7:0] ebus_d_out,
    output logic        ebus_d_oe,
    output logic  [4:0] ebus_ba,
    output logic        ebus_rom_ce_n,
    output logic        ebus_ram_ce_n,
    uart_if.host        uart
);

    localparam int CW = $clog2(`TX_FIFO_DEPTH) + 1;

    bank_reg_t  bank_r [4];
    bank_reg_t  cur_bank;
    logic [2:0] wr_n_r;
    logic [2:0] rd_n_r;
    logic [7:0] wrdata;
    logic [7:0] wr_port;
    logic       wr_io;
    logic       rd_espdata;
    logic       bus_write;
    logic       bus_read;
    logic       io_wr;

    logic       sel_io;
    logic       sel_sysram;
    logic       allow_mem;
    logic [7:0] keyb;
    logic [7:0] status_byte;
    logic [7:0] rd_mux;

    logic [CW-1:0] credit_cnt;
    logic          tx_busy;
    logic          tx_req;
    logic          flag_break;
    logic          flag_framing;
    logic          flag_overflow;

    ////////////////////////////////////////
    // Strobe synchronizer
    ////////////////////////////////////////

    // Data and port of the cycle, held until the strobe is seen high
    always_ff @(posedge sysclk) begin
        if (!ebus_wr_n) begin
            wrdata  <= ebus_d_in;
            wr_port <= ebus_a[7:0];
        end
    end

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            wr_n_r     <= '1;
            rd_n_r     <= '1;
            wr_io      <= 1'b0;
            rd_espdata <= 1'b0;
        end else begin
            wr_n_r <= {wr_n_r[1:0], ebus_wr_n};
            rd_n_r <= {rd_n_r[1:0], ebus_rd_n};
            if (!ebus_wr_n)
                wr_io <= !ebus_iorq_n;
            if (!ebus_rd_n)
                rd_espdata <= !ebus_iorq_n && ebus_a[7:0] == ESPDATA;
        end
    end

    // Rising strobe, acts on the third edge
    assign bus_write = wr_n_r[1] && !wr_n_r[2];
    assign bus_read  = rd_n_r[1] && !rd_n_r[2];
    assign io_wr     = bus_write && wr_io;

    ////////////////////////////////////////
    // Memory decoder
    ////////////////////////////////////////
    assign cur_bank   = bank_r[ebus_a[15:14]];
    assign sel_sysram = !ebus_mreq_n && cur_bank.overlay && ebus_a[15:11] == 5'b00111;
    assign allow_mem  = !ebus_mreq_n && !sel_sysram && (ebus_wr_n || !cur_bank.ro);

    assign ebus_rom_ce_n = !(allow_mem && cur_bank.page[5:4] == 2'b00);    // Pages 0-15
    assign ebus_ram_ce_n = !(sel_sysram || (allow_mem && cur_bank.page[5])); // Pages 32-63
    assign ebus_ba       = sel_sysram ? 5'd0 : cur_bank.page[4:0];

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            bank_r[0] <= `BANK0_RESET;
            bank_r[1] <= `BANK1_RESET;
            bank_r[2] <= `BANK2_RESET;
            bank_r[3] <= `BANK3_RESET;
        end else if (io_wr && wr_port inside {BANK0, BANK1, BANK2, BANK3}) begin
            bank_r[wr_port[1:0]] <= wrdata;
        end
    end

    ////////////////////////////////////////
    // I/O read path
    ////////////////////////////////////////

    // Rows with a low address bit are ANDed together
    always_comb begin
        keyb = 8'hFF;
        for (int row = 0; row < 8; row++) begin
            if (!ebus_a[8 + row])
                keyb = keyb & keys[8 * row +: 8];
        end
    end

    always_comb begin
        status_byte                  = 8'h00;
        status_byte[ST_RX_NOT_EMPTY] = uart.rx_not_empty;
        status_byte[ST_TX_BUSY]      = tx_busy;
        status_byte[ST_BREAK]        = flag_break;
        status_byte[ST_FRAMING]      = flag_framing;
        status_byte[ST_OVERFLOW]     = flag_overflow;
    end

    always_comb begin
        rd_mux = 8'h00;
        case (ebus_a[7:0])
            BANK0:   rd_mux = bank_r[0];
            BANK1:   rd_mux = bank_r[1];
            BANK2:   rd_mux = bank_r[2];
            BANK3:   rd_mux = bank_r[3];
            ESPCTRL: rd_mux = status_byte;
            ESPDATA: rd_mux = uart.rx_data;
            KEYB:    rd_mux = keyb;
            default: ;
        endcase
    end

    assign sel_io     = !ebus_iorq_n &&
                        ebus_a[7:0] inside {BANK0, BANK1, BANK2, BANK3, ESPCTRL, ESPDATA, KEYB};
    assign ebus_d_oe  = !ebus_rd_n && sel_io;
    assign ebus_d_out = rd_mux;

    assign uart.rx_pop = bus_read && rd_espdata && uart.rx_not_empty;

    ////////////////////////////////////////
    // Serial link control
    ////////////////////////////////////////
    assign tx_busy = credit_cnt == '0;
    assign tx_req  = io_wr && (wr_port == ESPDATA ||
                               (wr_port == ESPCTRL && wrdata[ST_TX_BREAK_REQ]));

    // Requests without a credit are dropped
    assign uart.tx_push  = tx_req && !tx_busy;
    assign uart.tx_entry = '{brk: wr_port == ESPCTRL, data: wrdata};

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            credit_cnt    <= CW'(`TX_FIFO_DEPTH);
            flag_break    <= 1'b0;
            flag_framing  <= 1'b0;
            flag_overflow <= 1'b0;
        end else begin
            case ({uart.tx_push, uart.tx_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: ;
            endcase

            // Write 1 to clear, a new event wins
            if (io_wr && wr_port == ESPCTRL) begin
                if (wrdata[ST_BREAK])
                    flag_break <= 1'b0;
                if (wrdata[ST_FRAMING])
                    flag_framing <= 1'b0;
                if (wrdata[ST_OVERFLOW])
                    flag_overflow <= 1'b0;
            end
            if (uart.rx_break)
                flag_break <= 1'b1;
            if (uart.rx_framing)
                flag_framing <= 1'b1;
            if (uart.rx_overflow)
                flag_overflow <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/z80_sys_top.sv
`timescale 1ns/10ps
`default_nettype none

module z80_sys_top (
    input  wire         sysclk,
    input  wire         reset,

    // Z80 bus, tristates split into in, out and enable
    input  wire  [15:0] ebus_a,
    input  wire   [7:0] ebus_d_in,
    output logic  [7:0] ebus_d_out,
    output logic        ebus_d_oe,
    input  wire         ebus_rd_n,
    input  wire         ebus_wr_n,
    input  wire         ebus_mreq_n,
    input  wire         ebus_iorq_n,
    output logic  [4:0] ebus_ba,
    output logic        ebus_rom_ce_n,
    output logic        ebus_ram_ce_n,

    // Keyboard matrix, 8 rows of 8
    input  wire  [63:0] keys,

    // ESP32 serial link
    output logic        esp_tx,
    input  wire         esp_rx,
    output logic        esp_rts,
    input  wire         esp_cts
);

    uart_if uart_i ();

    bus_ctrl bus_ctrl_i (
        .sysclk        (sysclk),
        .reset         (reset),
        .ebus_a        (ebus_a),
        .ebus_d_in     (ebus_d_in),
        .ebus_rd_n     (ebus_rd_n),
        .ebus_wr_n     (ebus_wr_n),
        .ebus_mreq_n   (ebus_mreq_n),
        .ebus_iorq_n   (ebus_iorq_n),
        .keys          (keys),
        .ebus_d_out    (ebus_d_out),
        .ebus_d_oe     (ebus_d_oe),
        .ebus_ba       (ebus_ba),
        .ebus_rom_ce_n (ebus_rom_ce_n),
        .ebus_ram_ce_n (ebus_ram_ce_n),
        .uart          (uart_i.host)
    );

    esp_uart esp_uart_i (
        .sysclk  (sysclk),
        .reset   (reset),
        .esp_rx  (esp_rx),
        .esp_cts (esp_cts),
        .esp_tx  (esp_tx),
        .esp_rts (esp_rts),
        .uart    (uart_i.dev)
    );

endmodule

`default_nettype wire

//--- test/bus_props.sv
`timescale 1ns/10ps
`include "sys_cfg.svh"
`default_nettype none

module bus_props (
    input wire                                 sysclk,
    input wire                                 reset,
    input wire                                 ebus_rd_n,
    input wire                                 ebus_d_oe,
    input wire                                 ebus_rom_ce_n,
    input wire                                 ebus_ram_ce_n,
    input wire [$clog2(`TX_FIFO_DEPTH):0]      credit_cnt
);

    // ROM and RAM must never drive the bus together
    assert property (@(posedge sysclk) disable iff (reset) ebus_rom_ce_n || ebus_ram_ce_n)
        else $error("ROM and RAM chip enables low together");

    assert property (@(posedge sysclk) disable iff (reset) ebus_rd_n |-> !ebus_d_oe)
        else $error("data bus driven outside a read");

    assert property (@(posedge sysclk) disable iff (reset) credit_cnt <= `TX_FIFO_DEPTH)
        else $error("transmit credits above queue depth");

endmodule

bind bus_ctrl bus_props props_i (
    .sysclk        (sysclk),
    .reset         (reset),
    .ebus_rd_n     (ebus_rd_n),
    .ebus_d_oe     (ebus_d_oe),
    .ebus_rom_ce_n (ebus_rom_ce_n),
    .ebus_ram_ce_n (ebus_ram_ce_n),
    .credit_cnt    (credit_cnt)
);

`default_nettype wire

//--- test/tb_top.sv
`timescale 1ns/10ps
`include "sys_cfg.svh"
`default_nettype none

module tb_top import zbus_pkg::*, uart_pkg::*; ();

    localparam int CLK_NS     = 40;
    localparam int CPB        = `UART_CLKS_PER_BIT;
    localparam int FRAME_CLKS = 11 * CPB;               // Frame plus one idle bit
    localparam int WATCHDOG_NS = (40 * FRAME_CLKS + 500 * 9 + 1000) * CLK_NS;

    logic        sysclk = 1'b0;
    logic        reset;
    logic [15:0] ebus_a;
    logic  [7:0] ebus_d_in;
    logic  [7:0] ebus_d_out;
    logic        ebus_d_oe;
    logic        ebus_rd_n, ebus_wr_n, ebus_mreq_n, ebus_iorq_n;
    logic  [4:0] ebus_ba;
    logic        ebus_rom_ce_n, ebus_ram_ce_n;
    logic [63:0] keys;
    logic        esp_tx, esp_rx, esp_rts, esp_cts;

    logic [31:0] seed = 32'h35a66015;
    logic  [7:0] banks [4];                             // Model copy of the bank registers
    logic  [8:0] line_q [$];                            // {break, data} seen on esp_tx
    string       name_q [$];
    logic [15:0] exp_q [$];
    logic [15:0] act_q [$];
    int          checks_issued = 0;
    int          checks_done   = 0;
    int          errors        = 0;
    int          errs_at_start = 0;

    z80_sys_top dut_i (
        .sysclk (sysclk), .reset (reset),
        .ebus_a (ebus_a), .ebus_d_in (ebus_d_in), .ebus_d_out (ebus_d_out),
        .ebus_d_oe (ebus_d_oe), .ebus_rd_n (ebus_rd_n), .ebus_wr_n (ebus_wr_n),
        .ebus_mreq_n (ebus_mreq_n), .ebus_iorq_n (ebus_iorq_n), .ebus_ba (ebus_ba),
        .ebus_rom_ce_n (ebus_rom_ce_n), .ebus_ram_ce_n (ebus_ram_ce_n), .keys (keys),
        .esp_tx (esp_tx), .esp_rx (esp_rx), .esp_rts (esp_rts), .esp_cts (esp_cts)
    );

    always #(CLK_NS / 2) sysclk = !sysclk;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    function automatic logic [31:0] rnd();
        seed = seed * 32'd1664525 + 32'd1013904223;     // LCG step
        return seed;
    endfunction

    // Expected {rom_ce_n, ram_ce_n, ba} for one memory cycle
    function automatic logic [6:0] mem_ref(input logic [7:0] bank, input logic [15:0] addr,
                                           input logic is_wr);
        logic       rom_n;
        logic       ram_n;
        logic [4:0] ba;
        rom_n = 1'b1;
        ram_n = 1'b1;
        ba    = bank[4:0];
        if (bank[6] && addr >= 16'h3800 && addr <= 16'h3FFF) begin
            ram_n = 1'b0;                               // Overlay system RAM
            ba    = 5'd0;
        end else if (!(is_wr && bank[7])) begin
            rom_n = !(bank[5:0] < 6'd16);
            ram_n = !(bank[5:0] >= 6'd32);
        end
        return {rom_n, ram_n, ba};
    endfunction

    // A key at 0 in any selected row pulls its column low
    function automatic logic [7:0] key_ref(input logic [63:0] k, input logic [7:0] rows);
        logic [7:0] v;
        v = 8'hFF;
        for (int n = 0; n < 64; n++) begin
            if (!rows[n / 8] && !k[n])
                v[n % 8] = 1'b0;
        end
        return v;
    endfunction

    task automatic expect_val(input string name, input logic [15:0] e, input logic [15:0] a);
        name_q.push_back(name);
        exp_q.push_back(e);
        act_q.push_back(a);
        checks_issued++;
    endtask

    task automatic report_fault(input string what);
        errors++;
        $display("%s", what);
    endtask

    task automatic finish_test(input string name);
        while (checks_done != checks_issued)
            @(posedge sysclk);
        $display("test %s finished with %0d errors", name, errors - errs_at_start);
        errs_at_start = errors;
    endtask

    ////////////////////////////////////////
    // Bus cycles
    ////////////////////////////////////////
    task automatic io_write(input logic [7:0] port, input logic [7:0] data);
        @(posedge sysclk);
        #2;
        ebus_a      = {8'h00, port};
        ebus_d_in   = data;
        ebus_iorq_n = 1'b0;
        ebus_wr_n   = 1'b0;
        repeat (4) @(posedge sysclk);
        #2;
        ebus_wr_n   = 1'b1;
        ebus_iorq_n = 1'b1;
        repeat (3) @(posedge sysclk);
    endtask

    task automatic io_read(input logic [15:0] addr, input string name, output logic [7:0] data);
        @(posedge sysclk);
        #2;
        ebus_a      = addr;
        ebus_iorq_n = 1'b0;
        ebus_rd_n   = 1'b0;
        repeat (2) @(negedge sysclk);
        data = ebus_d_out;
        expect_val({name, "_oe"}, 16'd1, {15'd0, ebus_d_oe});
        repeat (3) @(posedge sysclk);
        #2;
        ebus_rd_n   = 1'b1;
        ebus_iorq_n = 1'b1;
        repeat (3) @(posedge sysclk);
    endtask

    task automatic mem_cycle(input logic [15:0] addr, input logic is_wr, input logic [7:0] data);
        @(posedge sysclk);
        #2;
        ebus_a      = addr;
        ebus_d_in   = data;
        ebus_mreq_n = 1'b0;
        ebus_rd_n   = is_wr;
        ebus_wr_n   = !is_wr;
        repeat (2) @(negedge sysclk);
        expect_val("mem_map", {9'd0, mem_ref(banks[addr[15:14]], addr, is_wr)},
                   {9'd0, ebus_rom_ce_n, ebus_ram_ce_n, ebus_ba});
        expect_val("mem_oe", 16'd0, {15'd0, ebus_d_oe});
        repeat (3) @(posedge sysclk);
        #2;
        ebus_rd_n   = 1'b1;
        ebus_wr_n   = 1'b1;
        ebus_mreq_n = 1'b1;
        repeat (3) @(posedge sysclk);
    endtask

    ////////////////////////////////////////
    // Serial model
    ////////////////////////////////////////
    task automatic send_serial(input logic [7:0] data, input logic stop);
        @(posedge sysclk);
        #2 esp_rx = 1'b0;
        for (int i = 0; i < 10; i++) begin
            repeat (CPB) @(posedge sysclk);
            #2 esp_rx = (i < 8) ? data[i] : (i == 8 ? stop : 1'b1);
        end
        repeat (2 * CPB) @(posedge sysclk);
    endtask

    initial begin : line_rx
        logic [7:0] b;
        logic       stop;
        forever begin
            @(negedge esp_tx);
            repeat (CPB / 2) @(negedge sysclk);
            if (esp_tx == 1'b0) begin
                for (int i = 0; i < 8; i++) begin
                    repeat (CPB) @(negedge sysclk);
                    b[i] = esp_tx;
                end
                repeat (CPB) @(negedge sysclk);
                stop = esp_tx;
                line_q.push_back({!stop, b});   // Low stop bit marks a break
                wait (esp_tx === 1'b1);
            end
        end
    end

    task automatic wait_line(input int n);
        int cnt;
        cnt = 0;
        while (line_q.size() < n && cnt < (n + 1) * FRAME_CLKS) begin
            @(posedge sysclk);
            cnt++;
        end
        if (line_q.size() < n)
            report_fault("timeout waiting for a frame on esp_tx");
    endtask

    task automatic wait_rx_ready();
        logic [7:0] st;
        int         tries;
        tries = 0;
        st    = 8'h00;
        while (!st[ST_RX_NOT_EMPTY] && tries < 20) begin
            io_read({8'h00, ESPCTRL}, "rx_poll", st);
            tries++;
        end
        if (!st[ST_RX_NOT_EMPTY])
            report_fault("received byte never showed up in the status");
    endtask

    // Compare process, drains the queued checks
    initial begin : compare
        string       n;
        logic [15:0] e;
        logic [15:0] a;
        forever begin
            @(posedge sysclk);
            while (act_q.size() > 0) begin
                n = name_q.pop_front();
                e = exp_q.pop_front();
                a = act_q.pop_front();
                if (e !== a) begin
                    errors++;
                    $display("error %s: expected %h, actual %h", n, e, a);
                end
                checks_done++;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: run took longer than all tests should need");
        $display("Something failed");
        $finish;
    end

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////
    initial begin : main
        logic [31:0] r;
        logic  [7:0] d;
        logic  [7:0] sent [$];
        logic [15:0] addr;
        int          b;
        reset = 1'b1;
        ebus_a = '0;
        ebus_d_in = '0;
        ebus_rd_n = 1'b1;
        ebus_wr_n = 1'b1;
        ebus_mreq_n = 1'b1;
        ebus_iorq_n = 1'b1;
        keys = '1;
        esp_rx = 1'b1;
        esp_cts = 1'b0;
        banks = '{`BANK0_RESET, `BANK1_RESET, `BANK2_RESET, `BANK3_RESET};
        repeat (8) @(posedge sysclk);
        #2 reset = 1'b0;

        // 1: reset state and bank readback
        expect_val("reset_tx", 16'd1, {15'd0, esp_tx});
        expect_val("reset_rts", 16'd0, {15'd0, esp_rts});
        expect_val("reset_ce", 16'd3, {14'd0, ebus_rom_ce_n, ebus_ram_ce_n});
        expect_val("reset_oe", 16'd0, {15'd0, ebus_d_oe});
        for (int i = 0; i < 4; i++) begin
            io_read({8'h00, 8'hF0 + 8'(i)}, "bank_reset", d);
            expect_val("bank_reset", {8'd0, banks[i]}, {8'd0, d});
        end
        io_read({8'h00, ESPCTRL}, "status_reset", d);
        expect_val("status_reset", 16'd0, {8'd0, d});
        for (int i = 0; i < 4; i++) begin
            r = rnd();
            banks[i] = r[15:8];
            io_write(8'hF0 + 8'(i), banks[i]);
        end
        for (int i = 0; i < 4; i++) begin
            io_read({8'h00, 8'hF0 + 8'(i)}, "bank_rw", d);
            expect_val("bank_rw", {8'd0, banks[i]}, {8'd0, d});
        end
        finish_test("bank_regs");

        // 2: memory map, every fourth cycle in the overlay window
        for (int it = 0; it < 32; it++) begin
            r = rnd();
            b = (it % 4 == 0) ? 0 : int'(r[9:8]);
            banks[b] = r[23:16];
            io_write(8'hF0 + 8'(b), banks[b]);
            r = rnd();
            addr = (it % 4 == 0) ? {5'b00111, r[18:8]} : r[23:8];
            mem_cycle(addr, r[30], r[7:0]);
        end
        finish_test("memory_map");

        // 3: keyboard matrix
        for (int it = 0; it < 12; it++) begin
            r = rnd();
            #2 keys = {rnd(), r};
            r = rnd();
            io_read({r[15:8], KEYB}, "keyb", d);
            expect_val("keyb", {8'd0, key_ref(keys, r[15:8])}, {8'd0, d});
        end
        finish_test("keyboard");

        // 4: transmit in order, then a break
        for (int i = 0; i < 3; i++) begin
            r = rnd();
            sent.push_back(r[19:12]);
            io_write(ESPDATA, r[19:12]);
        end
        io_write(ESPCTRL, 8'h80);
        wait_line(4);
        for (int i = 0; i < 3 && line_q.size() > 0; i++)
            expect_val("tx_byte", {8'd0, sent.pop_front()}, {7'd0, line_q.pop_front()});
        if (line_q.size() > 0)
            expect_val("tx_break", 16'h0100, {7'd0, line_q.pop_front()});
        finish_test("transmit");

        // 5: CTS held high, credits run out
        sent.delete();
        #2 esp_cts = 1'b1;
        for (int i = 0; i < `TX_FIFO_DEPTH; i++) begin
            r = rnd();
            sent.push_back(r[23:16]);
            io_write(ESPDATA, r[23:16]);
        end
        io_read({8'h00, ESPCTRL}, "tx_busy", d);
        expect_val("tx_busy", 16'd1, {15'd0, d[ST_TX_BUSY]});
        io_write(ESPDATA, 8'hA5);                       // No credit, dropped
        repeat (FRAME_CLKS) @(posedge sysclk);
        expect_val("cts_hold", 16'd0, 16'(line_q.size()));
        #2 esp_cts = 1'b0;
        wait_line(`TX_FIFO_DEPTH);
        repeat (2 * FRAME_CLKS) @(posedge sysclk);
        expect_val("cts_count", 16'(`TX_FIFO_DEPTH), 16'(line_q.size()));
        while (line_q.size() > 0 && sent.size() > 0)
            expect_val("cts_byte", {8'd0, sent.pop_front()}, {7'd0, line_q.pop_front()});
        line_q.delete();
        finish_test("flow_control");

        // 6: receive, errors, overflow and flag clearing
        sent.delete();
        for (int i = 0; i < 3; i++) begin
            r = rnd();
            sent.push_back(r[27:20]);
            send_serial(r[27:20], 1'b1);
        end
        for (int i = 0; i < 3; i++) begin
            wait_rx_ready();
            io_read({8'h00, ESPDATA}, "rx_byte", d);
            expect_val("rx_byte", {8'd0, sent.pop_front()}, {8'd0, d});
        end
        io_read({8'h00, ESPCTRL}, "rx_drained", d);
        expect_val("rx_drained", 16'd0, {15'd0, d[ST_RX_NOT_EMPTY]});
        send_serial(8'h5A, 1'b0);
        send_serial(8'h00, 1'b0);
        io_read({8'h00, ESPCTRL}, "rx_errors", d);
        expect_val("rx_errors", 16'h000C, {8'd0, d});
        for (int i = 0; i <= `RX_FIFO_DEPTH; i++) begin
            r = rnd();
            sent.push_back(r[31:24]);
            send_serial(r[31:24], 1'b1);
            if (i == `RX_FIFO_DEPTH - 1)
                expect_val("rts_full", 16'd1, {15'd0, esp_rts});
        end
        io_read({8'h00, ESPCTRL}, "overflow", d);
        expect_val("overflow", 16'd1, {15'd0, d[ST_OVERFLOW]});
        for (int i = 0; i < `RX_FIFO_DEPTH; i++) begin
            io_read({8'h00, ESPDATA}, "rx_fill", d);
            expect_val("rx_fill", {8'd0, sent.pop_front()}, {8'd0, d});
        end
        io_write(ESPCTRL, 8'h1C);
        io_read({8'h00, ESPCTRL}, "flags_clear", d);
        expect_val("flags_clear", 16'd0, {8'd0, d});
        finish_test("receive");

        $display("checks %0d, errors %0d", checks_done, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+verilog
verilog/zbus_pkg.sv
verilog/uart_pkg.sv
verilog/uart_if.sv
verilog/sync_fifo.sv
verilog/esp_uart.sv
verilog/bus_ctrl.sv
verilog/z80_sys_top.sv
test/bus_props.sv
test/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_top -o tb_top_sim \
    && ./obj_dir/tb_top_sim 2>&1 | tee sim.log \
    || { echo "build or run did not complete"; exit 1; }

grep -qx "Everything OK" sim.log && exit 0 || exit 1
